//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= dataPath_tb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(FLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJDIR)

//--- build.f
+incdir+design
design/cpuPkg.sv
design/controlSequencer.sv
design/memInterface.sv
design/registerFile.sv
design/aluUnit.sv
design/busFabric.sv
design/dataPath.sv
sim/dataPath_assert.sv
sim/dataPath_tb.sv

//--- design/aluUnit.sv
`timescale 1ns/10ps
`include "cpu_defines.svh"

module aluUnit import cpuPkg::*; (
	input  logic                   clk,
	input  logic                   arstN,
	input  ctrlWordT               ctrl,
	input  logic [`WORD_WIDTH-1:0] bus,
	output logic [`WORD_WIDTH-1:0] zLow
);

	logic [`WORD_WIDTH-1:0] yReg;
	logic [`WORD_WIDTH-1:0] zReg;
	logic [`WORD_WIDTH-1:0] result;

	// Y is the left operand, the bus the right one
	always_comb begin
		case (ctrl.aluOp)
			opAnd:   result = yReg & bus;
			opOr:    result = yReg | bus;
			opAdd:   result = yReg + bus;
			opSub:   result = yReg - bus;
			default: result = bus; // pass through
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			yReg <= '0;
			zReg <= '0;
		end else begin
			if (ctrl.yIn) yReg <= bus;
			if (ctrl.zIn) zReg <= result;
		end
	end

	assign zLow = zReg;

endmodule

//--- design/busFabric.sv
`timescale 1ns/10ps
`include "cpu_defines.svh"

module busFabric import cpuPkg::*; (
	input  logic                       clk,
	input  logic                       arstN,
	input  ctrlWordT                   ctrl,
	input  logic [`WORD_WIDTH-1:0]     regOut,
	input  logic [`WORD_WIDTH-1:0]     mdrOut,
	input  logic [`WORD_WIDTH-1:0]     zLow,
	output logic [`WORD_WIDTH-1:0]     bus,
	output opcodeT                     opcode,
	output logic [`REG_ADDR_WIDTH-1:0] ra,
	output logic [`REG_ADDR_WIDTH-1:0] rb,
	output logic [`REG_ADDR_WIDTH-1:0] rc
);

	logic [`WORD_WIDTH-1:0] pc;
	instrT                  ir;
	logic [`WORD_WIDTH-1:0] addrExt;

	// word addressed, so the PC steps by one
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (ctrl.clrPc) begin
			pc <= '0;
		end else if (ctrl.incPc) begin
			pc <= pc + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) ir <= '0;
		else if (ctrl.irIn) ir <= instrT'(bus);
	end

	assign addrExt = {{(`WORD_WIDTH - ADDR_FIELD_WIDTH){1'b0}}, ir.address};

	// field decode
	assign opcode = ir.opcode;
	assign ra = ir.ra;
	assign rb = ir.rb;
	assign rc = ir.rc;

	always_comb begin
		case (ctrl.busSrc)
			busReg:  bus = regOut;
			busMdr:  bus = mdrOut;
			busZLow: bus = zLow;
			busAddr: bus = addrExt;
			default: bus = pc;
		endcase
	end

endmodule

//--- design/controlSequencer.sv
`timescale 1ns/10ps
`include "cpu_defines.svh"

module controlSequencer import cpuPkg::*; (
	input  logic     clk,
	input  logic     arstN,
	input  logic     start,
	input  opcodeT   opcode,
	input  logic     memDone,
	output ctrlWordT ctrl,
	output logic     halted
);

	typedef enum logic [2:0] {
		sIdle,
		sFetch0,
		sFetch1,
		sFetch2,
		sExec0,
		sExec1,
		sExec2,
		sHalt
	} stateT;

	stateT state;
	stateT nextState;
	logic  isAluOp;
	logic  restart;

	assign isAluOp = (opcode == opAnd) || (opcode == opOr) ||
		(opcode == opAdd) || (opcode == opSub);
	assign restart = start && (state == sIdle || state == sHalt);

	always_comb begin
		ctrl = '0;
		ctrl.busSrc = busPc;
		nextState = state;
		case (state)
			sIdle, sHalt: begin
				ctrl.clrPc = restart;
				if (restart) nextState = sFetch0;
			end
			sFetch0: begin // PC out, MAR in, bump PC
				ctrl.busSrc = busPc;
				ctrl.marIn = 1'b1;
				ctrl.incPc = 1'b1;
				nextState = sFetch1;
			end
			sFetch1: begin
				ctrl.memRead = 1'b1;
				nextState = sFetch2;
			end
			sFetch2: begin
				ctrl.busSrc = busMdr;
				ctrl.irIn = 1'b1;
				nextState = sExec0;
			end
			sExec0: begin
				nextState = sExec1;
				if (isAluOp) begin
					ctrl.busSrc = busReg; // rb into Y
					ctrl.regSel = selRb;
					ctrl.yIn = 1'b1;
				end else if (opcode == opLoad || opcode == opStore) begin
					ctrl.busSrc = busAddr;
					ctrl.marIn = 1'b1;
				end else begin
					nextState = sHalt; // halt and anything undefined
				end
			end
			sExec1: begin
				nextState = sExec2;
				if (isAluOp) begin
					ctrl.busSrc = busReg; // rc through the ALU
					ctrl.regSel = selRc;
					ctrl.zIn = 1'b1;
					ctrl.aluOp = opcode;
				end else if (opcode == opLoad) begin
					ctrl.memRead = 1'b1;
				end else begin
					ctrl.busSrc = busReg; // store data into MDR
					ctrl.regSel = selRa;
					ctrl.mdrIn = 1'b1;
				end
			end
			sExec2: begin
				nextState = sFetch0;
				ctrl.regSel = selRa;
				if (isAluOp) begin
					ctrl.busSrc = busZLow;
					ctrl.regIn = 1'b1;
				end else if (opcode == opLoad) begin
					ctrl.busSrc = busMdr;
					ctrl.regIn = 1'b1;
				end else begin
					ctrl.memWrite = 1'b1;
				end
			end
			default: nextState = sIdle;
		endcase

		// hold the step while memory is busy
		if ((ctrl.memRead || ctrl.memWrite) && !memDone) nextState = state;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= sIdle;
			halted <= 1'b0;
		end else begin
			state <= nextState;
			halted <= (nextState == sHalt);
		end
	end

endmodule

//--- design/cpuPkg.sv
`include "cpu_defines.svh"

package cpuPkg;

	// instruction opcodes, 5 bits at the top of the word
	typedef enum logic [4:0] {
		opLoad  = 5'd0,
		opStore = 5'd1,
		opAnd   = 5'd2,
		opOr    = 5'd3,
		opAdd   = 5'd4,
		opSub   = 5'd5,
		opHalt  = 5'd6
	} opcodeT;

	// whatever is left below the three register fields
	localparam int ADDR_FIELD_WIDTH = `WORD_WIDTH - 5 - 3 * `REG_ADDR_WIDTH;

	typedef struct packed {
		opcodeT                     opcode;
		logic [`REG_ADDR_WIDTH-1:0] ra; // destination, or source of a store
		logic [`REG_ADDR_WIDTH-1:0] rb;
		logic [`REG_ADDR_WIDTH-1:0] rc;
		logic [ADDR_FIELD_WIDTH-1:0] address; // zero-extended onto the bus
	} instrT;

	// who drives the shared bus
	typedef enum logic [2:0] {
		busReg  = 3'd0,
		busPc   = 3'd1,
		busMdr  = 3'd2,
		busZLow = 3'd3,
		busAddr = 3'd4
	} busSrcT;

	// which instruction field indexes the register file
	typedef enum logic [1:0] {
		selRa = 2'd0,
		selRb = 2'd1,
		selRc = 2'd2
	} regSelT;

	// one micro-step worth of control
	typedef struct packed {
		busSrcT busSrc;
		regSelT regSel;
		logic   regIn;
		logic   pcIn;
		logic   irIn;
		logic   marIn;
		logic   mdrIn;
		logic   yIn;
		logic   zIn;
		logic   incPc;
		logic   clrPc;    // restart at address zero
		logic   memRead;
		logic   memWrite;
		opcodeT aluOp;
	} ctrlWordT;

endpackage

//--- design/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and address width
`define WORD_WIDTH 32

// general register file size
`define REG_COUNT 16

// width of a register index, log2 of REG_COUNT
`define REG_ADDR_WIDTH 4

`endif

//--- design/dataPath.sv
`timescale 1ns/10ps
`include "cpu_defines.svh"

module dataPath import cpuPkg::*; (
	input  logic                   clk,
	input  logic                   arstN,
	input  logic                   start,
	output logic                   halted,
	output logic [`WORD_WIDTH-1:0] paddr,
	output logic                   psel,
	output logic                   penable,
	output logic                   pwrite,
	output logic [`WORD_WIDTH-1:0] pwdata,
	input  logic [`WORD_WIDTH-1:0] prdata,
	input  logic                   pready
);

	ctrlWordT                   ctrl;
	opcodeT                     opcode;
	logic                       memDone;
	logic [`WORD_WIDTH-1:0]     bus;
	logic [`WORD_WIDTH-1:0]     regOut;
	logic [`WORD_WIDTH-1:0]     mdrOut;
	logic [`WORD_WIDTH-1:0]     zLow;
	logic [`REG_ADDR_WIDTH-1:0] ra;
	logic [`REG_ADDR_WIDTH-1:0] rb;
	logic [`REG_ADDR_WIDTH-1:0] rc;

	controlSequencer i_controlSequencer (
		.clk, .arstN, .start, .opcode, .memDone, .ctrl, .halted
	);

	busFabric i_busFabric (
		.clk, .arstN, .ctrl, .regOut, .mdrOut, .zLow, .bus, .opcode, .ra, .rb, .rc
	);

	registerFile i_registerFile (
		.clk, .arstN, .ctrl, .ra, .rb, .rc, .bus, .regOut
	);

	aluUnit i_aluUnit (
		.clk, .arstN, .ctrl, .bus, .zLow
	);

	// APB requester toward the external memory
	memInterface i_memInterface (
		.clk, .arstN, .ctrl, .bus, .mdrOut, .memDone,
		.paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready
	);

endmodule

//--- design/memInterface.sv
`timescale 1ns/10ps
`include "cpu_defines.svh"

module memInterface import cpuPkg::*; (
	input  logic                   clk,
	input  logic                   arstN,
	input  ctrlWordT               ctrl,
	input  logic [`WORD_WIDTH-1:0] bus,
	output logic [`WORD_WIDTH-1:0] mdrOut,
	output logic                   memDone,
	output logic [`WORD_WIDTH-1:0] paddr,
	output logic                   psel,
	output logic                   penable,
	output logic                   pwrite,
	output logic [`WORD_WIDTH-1:0] pwdata,
	input  logic [`WORD_WIDTH-1:0] prdata,
	input  logic                   pready
);

	logic [`WORD_WIDTH-1:0] mar;
	logic [`WORD_WIDTH-1:0] mdr;
	logic                   memReq;
	logic                   xferEnd;

	assign memReq = ctrl.memRead | ctrl.memWrite;
	assign xferEnd = psel & penable & pready; // last access cycle

	// setup for one cycle, then access until pready
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			psel <= 1'b0;
			penable <= 1'b0;
			pwrite <= 1'b0;
		end else if (!psel) begin
			if (memReq) begin
				psel <= 1'b1;
				pwrite <= ctrl.memWrite;
			end
		end else if (!penable) begin
			penable <= 1'b1;
		end else if (pready) begin
			psel <= 1'b0;
			penable <= 1'b0;
			pwrite <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.marIn) mar <= bus;
	end

	// finished read first, else a load from the bus
	always_ff @(posedge clk) begin
		if (xferEnd && !pwrite) mdr <= prdata;
		else if (ctrl.mdrIn) mdr <= bus;
	end

	// MAR and MDR are untouched during a transfer
	assign paddr = mar;
	assign pwdata = mdr;
	assign mdrOut = mdr;
	assign memDone = xferEnd;

endmodule

//--- design/registerFile.sv
`timescale 1ns/10ps
`include "cpu_defines.svh"

module registerFile import cpuPkg::*; (
	input  logic                       clk,
	input  logic                       arstN,
	input  ctrlWordT                   ctrl,
	input  logic [`REG_ADDR_WIDTH-1:0] ra,
	input  logic [`REG_ADDR_WIDTH-1:0] rb,
	input  logic [`REG_ADDR_WIDTH-1:0] rc,
	input  logic [`WORD_WIDTH-1:0]     bus,
	output logic [`WORD_WIDTH-1:0]     regOut
);

	logic [`WORD_WIDTH-1:0]     regs [`REG_COUNT];
	logic [`REG_ADDR_WIDTH-1:0] sel;

	always_comb begin
		case (ctrl.regSel)
			selRb:   sel = rb;
			selRc:   sel = rc;
			default: sel = ra;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++) regs[i] <= '0;
		end else if (ctrl.regIn) begin
			regs[sel] <= bus;
		end
	end

	assign regOut = regs[sel]; // same index for read and write

endmodule

//--- sim/dataPath_assert.sv
`timescale 1ns/10ps
`include "cpu_defines.svh"

module dataPath_assert import cpuPkg::*; (
	input logic                   clk,
	input logic                   arstN,
	input logic                   psel,
	input logic                   penable,
	input logic                   pwrite,
	input logic                   pready,
	input logic                   halted,
	input logic [`WORD_WIDTH-1:0] paddr,
	input logic [`WORD_WIDTH-1:0] pwdata,
	input ctrlWordT               ctrl
);

	penableNeedsPsel: assert property (@(posedge clk) disable iff (!arstN)
		penable |-> psel) else $error("penable high without psel");

	// one setup cycle, then access
	setupThenAccess: assert property (@(posedge clk) disable iff (!arstN)
		psel && !penable |=> psel && penable) else $error("setup not followed by access");

	accessAfterSetup: assert property (@(posedge clk) disable iff (!arstN)
		$rose(penable) |-> $past(psel && !penable)) else $error("access without setup");

	// address, direction and write data held until pready
	stableInXfer: assert property (@(posedge clk) disable iff (!arstN)
		psel && !(penable && pready) |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
		else $error("APB request changed mid transfer");

	// sequencer keeps its memory step for the whole transfer
	requestHeld: assert property (@(posedge clk) disable iff (!arstN)
		psel |-> (ctrl.memRead || ctrl.memWrite) && (pwrite == ctrl.memWrite))
		else $error("memory step dropped or changed mid transfer");

	haltedQuiet: assert property (@(posedge clk) disable iff (!arstN)
		halted |-> !psel) else $error("bus activity while halted");

endmodule

bind dataPath dataPath_assert i_dataPathAssert (
	.clk(clk), .arstN(arstN), .psel(psel), .penable(penable), .pwrite(pwrite),
	.pready(pready), .halted(halted), .paddr(paddr), .pwdata(pwdata), .ctrl(ctrl)
);

//--- sim/dataPath_tb.sv
`timescale 1ns/10ps
`include "cpu_defines.svh"

module dataPath_tb import cpuPkg::*; ();

	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
		opcodeT      op;
		logic [14:0] storeAddr;
		logic [31:0] expected; // a op b, modulo 2^32
	} stimRowT;

	localparam int ROWS = 6;
	localparam int TIMEOUT = 500; // cycles per program run

	stimRowT stimTable [ROWS] = '{
		'{32'hF0F0_1234, 32'h0FF0_FF00, opAnd, 15'h040, 32'h00F0_1200},
		'{32'h1200_0034, 32'h0045_6700, opOr,  15'h041, 32'h1245_6734},
		'{32'hFFFF_FFFF, 32'h0000_0002, opAdd, 15'h050, 32'h0000_0001},
		'{32'h1234_5678, 32'h1111_1111, opAdd, 15'h060, 32'h2345_6789},
		'{32'h0000_0005, 32'h0000_0007, opSub, 15'h07F, 32'hFFFF_FFFE},
		'{32'hA5A5_A5A5, 32'h0505_0505, opSub, 15'h044, 32'hA0A0_A0A0}
	};

	logic                   clk = 1'b0;
	logic                   arstN;
	logic                   start;
	logic                   halted;
	logic [`WORD_WIDTH-1:0] paddr;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`WORD_WIDTH-1:0] pwdata;
	logic [`WORD_WIDTH-1:0] prdata;
	logic                   pready;

	logic [31:0] mem [256];
	logic [31:0] transAddr [$]; // every completed APB transfer
	logic        transWrite [$];
	logic [31:0] transData [$];
	logic [7:0]  lfsrState;
	bit          useWaits;
	bit          inAccess;
	int          waitLeft;
	int          errors;
	int          timeouts;

	dataPath i_dataPath (
		.clk, .arstN, .start, .halted, .paddr, .psel, .penable, .pwrite,
		.pwdata, .prdata, .pready
	);

	always #4 clk = ~clk;

	// taps 8,6,5,4
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsrState[7] ^ lfsrState[5] ^ lfsrState[4] ^ lfsrState[3];
		lfsrState = {lfsrState[6:0], fb};
		return fb;
	endfunction

	function automatic int drawWaits();
		logic [1:0] w;
		w[0] = lfsrBit();
		w[1] = lfsrBit();
		return int'(w);
	endfunction

	function automatic logic [31:0] assemble(opcodeT op, logic [3:0] ra, logic [3:0] rb,
		logic [3:0] rc, logic [14:0] addr);
		instrT ins;
		ins.opcode = op;
		ins.ra = ra;
		ins.rb = rb;
		ins.rc = rc;
		ins.address = addr;
		return ins;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// APB memory, answers 1 ns after each edge
	always @(posedge clk) begin
		#1;
		if (!arstN || !(psel && penable)) begin
			pready = 1'b0;
			inAccess = 1'b0;
		end else begin
			if (!inAccess) begin
				inAccess = 1'b1;
				waitLeft = useWaits ? drawWaits() : 0;
			end
			if (waitLeft > 0) begin
				pready = 1'b0;
				waitLeft--;
			end else begin
				pready = 1'b1;
				transAddr.push_back(paddr);
				transWrite.push_back(pwrite);
				if (pwrite) mem[paddr[7:0]] = pwdata;
				else prdata = mem[paddr[7:0]];
				transData.push_back(pwrite ? pwdata : mem[paddr[7:0]]);
			end
		end
	end

	task automatic waitHalted(output bit ok);
		ok = 1'b0;
		for (int c = 0; c < TIMEOUT; c++) begin
			@(posedge clk);
			#1;
			if (halted) begin
				ok = 1'b1;
				break;
			end
		end
	endtask

	task automatic runRow(input int idx, input int pass);
		stimRowT     row;
		logic [31:0] expAddr [8];
		bit          ok;
		row = stimTable[idx];
		mem[0] = assemble(opLoad, 4'd2, 4'd0, 4'd0, 15'd16);
		mem[1] = assemble(opLoad, 4'd3, 4'd0, 4'd0, 15'd17);
		mem[2] = assemble(row.op, 4'd1, 4'd2, 4'd3, 15'd0);
		mem[3] = assemble(opStore, 4'd1, 4'd0, 4'd0, row.storeAddr);
		mem[4] = assemble(opHalt, 4'd0, 4'd0, 4'd0, 15'd0);
		mem[16] = row.a;
		mem[17] = row.b;
		expAddr = '{32'd0, 32'd16, 32'd1, 32'd17, 32'd2, 32'd3, 32'(row.storeAddr), 32'd4};
		transAddr.delete();
		transWrite.delete();
		transData.delete();

		@(posedge clk);
		#1 start = 1'b1;
		@(posedge clk);
		#1 start = 1'b0;
		checkValue("halted after start", 32'(halted), 32'd0);

		waitHalted(ok);
		if (!ok) begin
			timeouts++;
			$display("Timeout: halted never rose (pass %0d, row %0d)", pass, idx);
		end else begin
			checkValue("transfer count", 32'(transAddr.size()), 32'd8);
			if (transAddr.size() == 8) begin
				for (int i = 0; i < 8; i++) begin
					checkValue($sformatf("paddr[%0d]", i), transAddr[i], expAddr[i]);
					checkValue($sformatf("pwrite[%0d]", i), 32'(transWrite[i]), 32'(i == 6));
				end
				checkValue("pwdata", transData[6], row.expected);
			end
			repeat (4) @(posedge clk);
			#1;
			checkValue("halted held", 32'(halted), 32'd1);
		end
	endtask

	initial begin
		arstN = 1'b0;
		start = 1'b0;
		pready = 1'b0;
		prdata = '0;
		errors = 0;
		timeouts = 0;
		lfsrState = 8'd91;
		useWaits = 1'b0;
		for (int i = 0; i < 256; i++) mem[i] = 32'hC0DE_0000 | 32'(i);

		repeat (16) @(posedge clk);
		#1 arstN = 1'b1;
		checkValue("psel", 32'(psel), 32'd0);
		checkValue("penable", 32'(penable), 32'd0);
		checkValue("halted", 32'(halted), 32'd0);

		// first pass with zero wait states, second with random ones
		for (int pass = 0; pass < 2 && timeouts == 0; pass++) begin
			useWaits = (pass == 1);
			for (int r = 0; r < ROWS && timeouts == 0; r++) runRow(r, pass);
		end

		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
